// ==== compile.f ====
hdl/usb_tx_pkg.sv
hdl/usb_tx_sequencer.sv
hdl/usb_bit_stuffer.sv
hdl/usb_nrzi_driver.sv
hdl/usb_tx_top.sv
testbench/usb_line_monitor.sv
testbench/tb_usb_tx.sv

// ==== hdl/usb_bit_stuffer.sv ====
// ------------------------------
// USB TX bit stuffer
// Serializes bytes LSB first and
// inserts a zero after six ones,
// one line bit per bit time
// ------------------------------

`timescale 1ns/1ps

module usb_bit_stuffer
	import usb_tx_pkg::*;
(
	input  logic       usb_clk,
	input  logic       usb_rst,
	input  logic       bit_en,
	input  stuff_ctl_t stuff_ctl,
	input  usb_byte_t  tx_data,
	output logic       line_bit,
	output logic       stuff_done
);

	logic [6:0]  shift_reg; // bits still waiting, next one in bit 0
	bit_index_t  bit_idx;   // index of the data bit now on line_bit
	ones_count_t ones_run;

	// the stuffed zero is due once the run has reached six
	logic stuff_now;
	assign stuff_now = (ones_run == 3'd6);

	// control state, cleared by reset or by the sequencer between packets
	always_ff @(posedge usb_clk) begin
		if (usb_rst || stuff_ctl.clear) begin
			stuff_done <= 1'b1;
			ones_run   <= '0;
			bit_idx    <= '0;
		end else if (bit_en) begin
			if (stuff_ctl.load) begin
				stuff_done <= 1'b0;
				bit_idx    <= '0;
				// the run carries over from the previous byte of the packet
				ones_run   <= tx_data[0] ? ones_run + 3'd1 : 3'd0;
			end else if (!stuff_done) begin
				if (stuff_now) begin
					ones_run <= '0; // the stuffed zero breaks the run
					if (bit_idx == 3'd7)
						stuff_done <= 1'b1;
				end else begin
					bit_idx  <= bit_idx + 3'd1;
					ones_run <= shift_reg[0] ? ones_run + 3'd1 : 3'd0;
					// after bit 7 the byte is only finished if it needs no stuffing
					if (bit_idx == 3'd6 && !(shift_reg[0] && ones_run == 3'd5))
						stuff_done <= 1'b1;
				end
			end
		end
	end

	// payload path
	always_ff @(posedge usb_clk) begin
		if (bit_en) begin
			if (stuff_ctl.load) begin
				line_bit  <= tx_data[0];
				shift_reg <= tx_data[7:1];
			end else if (!stuff_done && !stuff_ctl.clear) begin
				if (stuff_now) begin
					line_bit <= 1'b0;
				end else begin
					line_bit  <= shift_reg[0];
					shift_reg <= {1'b0, shift_reg[6:1]};
				end
			end
		end
	end

	a_run_limit: assert property (@(posedge usb_clk) disable iff (usb_rst)
		ones_run <= 3'd6);

endmodule

// ==== hdl/usb_nrzi_driver.sv ====
// ------------------------------
// USB TX line driver
// NRZI-encodes the stuffer output
// or forces SE0/J, with a second
// register stage toward the pads
// ------------------------------

`timescale 1ns/1ps

module usb_nrzi_driver
	import usb_tx_pkg::*;
(
	input  logic      usb_clk,
	input  logic      usb_rst,
	input  logic      bit_en,
	input  logic      line_bit,
	input  line_ctl_t line_ctl,
	output logic      txp,
	output logic      txm,
	output logic      txoe
);

	logic txp_r;
	logic txm_r;
	logic txoe_r;

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			txp_r  <= 1'b1; // idle J
			txm_r  <= 1'b0;
			txoe_r <= 1'b0;
		end else if (bit_en) begin
			txoe_r <= line_ctl.oe;
			if (!line_ctl.oe) begin
				txp_r <= 1'b1; // released pair returns to J
				txm_r <= 1'b0;
			end else begin
				case (line_ctl.mode)
					LINE_DATA: begin
						// a zero toggles the pair, a one holds it
						// txm_r takes the old txp_r so a toggle out of SE0 lands on J
						if (!line_bit) begin
							txp_r <= ~txp_r;
							txm_r <= txp_r;
						end
					end
					LINE_SE0: begin
						txp_r <= 1'b0;
						txm_r <= 1'b0;
					end
					default: begin
						txp_r <= 1'b1;
						txm_r <= 1'b0;
					end
				endcase
			end
		end
	end

	// pad stage, one clock behind the encoder
	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			txp  <= 1'b1;
			txm  <= 1'b0;
			txoe <= 1'b0;
		end else begin
			txp  <= txp_r;
			txm  <= txm_r;
			txoe <= txoe_r;
		end
	end

	a_no_se1: assert property (@(posedge usb_clk) disable iff (usb_rst)
		!(txp && txm));

endmodule

// ==== hdl/usb_tx_pkg.sv ====
// ------------------------------
// USB 1.1 transmit engine types
// Shared vector typedefs, the
// sequencer and line-mode enums
// and the control structs that
// pass between the TX blocks
// ------------------------------

package usb_tx_pkg;

	// one byte as handed over by the byte source, sent LSB first
	typedef logic [7:0] usb_byte_t;

	typedef logic [2:0] bit_index_t;  // bit position inside the current byte

	typedef logic [2:0] ones_count_t; // run of consecutive ones, 0 to 6

	// packet sequencer states
	typedef enum logic [2:0] {
		TX_IDLE = 3'd0,
		TX_DATA = 3'd1,
		TX_EOP1 = 3'd2,
		TX_EOP2 = 3'd3,
		TX_J    = 3'd4
	} tx_state_t;

	// what the driver puts on D+/D- during a bit time
	typedef enum logic [1:0] {
		LINE_DATA = 2'd0, // NRZI of the stuffer output
		LINE_SE0  = 2'd1, // both lines low
		LINE_J    = 2'd2  // D+ high, D- low
	} line_mode_t;

	// commands from the sequencer to the bit stuffer
	typedef struct packed {
		logic clear; // empty the stuffer and zero the ones run
		logic load;  // take a new byte at the next bit time
	} stuff_ctl_t;

	// commands from the sequencer to the line driver
	typedef struct packed {
		logic       oe;   // drive the pair during this bit time
		line_mode_t mode;
	} line_ctl_t;

endpackage

// ==== hdl/usb_tx_sequencer.sv ====
// ------------------------------
// USB TX packet sequencer
// Divides usb_clk down to the bit
// rate, runs the packet FSM, hands
// out ready pulses and issues the
// stuffer and line commands
// ------------------------------

`timescale 1ns/1ps

module usb_tx_sequencer
	import usb_tx_pkg::*;
#(
	parameter int CLKS_PER_BIT = 4
) (
	input  logic       usb_clk,
	input  logic       usb_rst,
	input  logic       tx_valid,
	input  logic       generate_reset,
	input  logic       stuff_done,
	output logic       bit_en,
	output logic       tx_ready,
	output stuff_ctl_t stuff_ctl,
	output line_ctl_t  line_ctl
);

	localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);

	logic [CNT_W-1:0] clk_cnt;
	tx_state_t        state;
	tx_state_t        next_state;

	// bit_en is registered, so it is a clean one-cycle pulse per bit time
	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			clk_cnt <= '0;
			bit_en  <= 1'b0;
		end else begin
			bit_en <= (clk_cnt == CNT_LAST);
			if (clk_cnt == CNT_LAST)
				clk_cnt <= '0;
			else
				clk_cnt <= clk_cnt + 1'b1;
		end
	end

	always_ff @(posedge usb_clk) begin
		if (usb_rst)
			state <= TX_IDLE;
		else if (bit_en)
			state <= next_state; // the FSM only moves at bit boundaries
	end

	// the byte is accepted at the bit_en that loads it, ready follows one clock later
	always_ff @(posedge usb_clk) begin
		if (usb_rst)
			tx_ready <= 1'b0;
		else
			tx_ready <= bit_en && stuff_ctl.load;
	end

	always_comb begin
		next_state      = state;
		stuff_ctl.clear = 1'b0;
		stuff_ctl.load  = 1'b0;
		line_ctl.oe     = 1'b1;
		line_ctl.mode   = LINE_DATA;

		case (state)
			TX_IDLE: begin
				// bus reset is only honoured while no packet is running
				line_ctl.oe   = generate_reset;
				line_ctl.mode = generate_reset ? LINE_SE0 : LINE_DATA;
				if (tx_valid) begin
					stuff_ctl.load = 1'b1;
					next_state     = TX_DATA;
				end else begin
					stuff_ctl.clear = 1'b1; // every packet starts with a fresh ones run
				end
			end
			TX_DATA: begin
				if (stuff_done) begin
					if (tx_valid)
						stuff_ctl.load = 1'b1;
					else
						next_state = TX_EOP1; // valid low at a byte boundary ends the packet
				end
			end
			TX_EOP1: begin
				stuff_ctl.clear = 1'b1;
				line_ctl.mode   = LINE_SE0;
				next_state      = TX_EOP2;
			end
			TX_EOP2: begin
				stuff_ctl.clear = 1'b1;
				line_ctl.mode   = LINE_SE0;
				next_state      = TX_J;
			end
			TX_J: begin
				stuff_ctl.clear = 1'b1;
				line_ctl.mode   = LINE_J;
				next_state      = TX_IDLE; // oe drops in idle and releases the pair
			end
			default: begin
				line_ctl.oe = 1'b0;
				next_state  = TX_IDLE;
			end
		endcase
	end

	// the source must see each acceptance as a separate pulse
	a_ready_single: assert property (@(posedge usb_clk) disable iff (usb_rst)
		tx_ready |=> !tx_ready);

	// a byte that is taken always leads into, or continues, the data phase
	a_load_state: assert property (@(posedge usb_clk) disable iff (usb_rst)
		bit_en && stuff_ctl.load |=> state == TX_DATA);

endmodule

// ==== hdl/usb_tx_top.sv ====
// ------------------------------
// USB 1.1 transmit engine top
// Ties the sequencer, the bit
// stuffer and the line driver
// together and sets the bit rate
// ------------------------------

`timescale 1ns/1ps

module usb_tx_top
	import usb_tx_pkg::*;
#(
	parameter int CLKS_PER_BIT = 4 // 4 for full speed at 48 MHz, 32 for low speed
) (
	input  logic      usb_clk,
	input  logic      usb_rst,
	input  usb_byte_t tx_data,
	input  logic      tx_valid,
	input  logic      generate_reset,
	output logic      tx_ready,
	output logic      txp,
	output logic      txm,
	output logic      txoe
);

	logic       bit_en;
	logic       stuff_done;
	logic       line_bit;
	stuff_ctl_t stuff_ctl;
	line_ctl_t  line_ctl;

	usb_tx_sequencer #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_sequencer (
		.usb_clk        (usb_clk),
		.usb_rst        (usb_rst),
		.tx_valid       (tx_valid),
		.generate_reset (generate_reset),
		.stuff_done     (stuff_done),
		.bit_en         (bit_en),
		.tx_ready       (tx_ready),
		.stuff_ctl      (stuff_ctl),
		.line_ctl       (line_ctl)
	);

	usb_bit_stuffer u_stuffer (
		.usb_clk    (usb_clk),
		.usb_rst    (usb_rst),
		.bit_en     (bit_en),
		.stuff_ctl  (stuff_ctl),
		.tx_data    (tx_data),
		.line_bit   (line_bit),
		.stuff_done (stuff_done)
	);

	usb_nrzi_driver u_driver (
		.usb_clk  (usb_clk),
		.usb_rst  (usb_rst),
		.bit_en   (bit_en),
		.line_bit (line_bit),
		.line_ctl (line_ctl),
		.txp      (txp),
		.txm      (txm),
		.txoe     (txoe)
	);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the USB TX testbench with Verilator, runs it and checks the log

set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_usb_tx \
	-f compile.f \
	-o sim_usb_tx

./obj_dir/sim_usb_tx | tee "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
	echo "simulation reported failures"
	exit 1
fi
echo "simulation finished without failures"

// ==== testbench/tb_usb_tx.sv ====
// ------------------------------
// USB TX engine testbench
// Sends table and random packets
// and a bus reset, and checks the
// decoded line against the table
// ------------------------------

`timescale 1ns/1ps

module tb_usb_tx;

	localparam int CLKS_PER_BIT = 4;
	localparam int CLK_PERIOD   = 4;
	localparam int NUM_FIXED    = 8;
	localparam int NUM_ROWS     = NUM_FIXED + 4; // fixed rows, then random packets

	logic        usb_clk;
	logic        usb_rst;
	logic [7:0]  tx_data;
	logic        tx_valid;
	logic        generate_reset;
	logic        tx_ready;
	logic        txp;
	logic        txm;
	logic        txoe;
	int          row_len   [NUM_ROWS];
	logic [63:0] row_bytes [NUM_ROWS]; // byte 0 in bits 7:0
	logic        row_reset [NUM_ROWS];
	int          row_stuff [NUM_ROWS];
	int          ready_pulses = 0;
	int          error_count  = 0;
	int          tests_run    = 0;
	int          tests_failed = 0;
	logic        table_ready  = 1'b0;

	usb_tx_top #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_dut (
		.usb_clk        (usb_clk),
		.usb_rst        (usb_rst),
		.tx_data        (tx_data),
		.tx_valid       (tx_valid),
		.generate_reset (generate_reset),
		.tx_ready       (tx_ready),
		.txp            (txp),
		.txm            (txm),
		.txoe           (txoe)
	);

	usb_line_monitor #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_monitor (
		.usb_clk (usb_clk),
		.txp     (txp),
		.txm     (txm),
		.txoe    (txoe)
	);

	always #(CLK_PERIOD / 2) usb_clk = ~usb_clk;

	always @(negedge usb_clk) begin
		if (tx_ready)
			ready_pulses++;
	end

	// completed runs of six ones in the LSB-first stream, each run restarts after six
	function automatic int count_six_runs(input int len, input logic [63:0] bytes);
		int runs;
		int ones;
		runs = 0;
		ones = 0;
		for (int i = 0; i < len * 8; i++) begin
			ones = bytes[i] ? ones + 1 : 0;
			if (ones == 6) begin
				runs++;
				ones = 0;
			end
		end
		return runs;
	endfunction

	task automatic set_row(input int idx, input int len, input logic rst, input int stuff,
		input logic [63:0] bytes);
		row_len[idx]   = len;
		row_reset[idx] = rst;
		row_stuff[idx] = stuff;
		row_bytes[idx] = bytes;
	endtask

	task automatic check_value(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("[ERROR] t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, got);
			error_count++;
		end
	endtask

	task automatic wait_monitor(input int start_count, input int max_clks);
		int waited;
		waited = 0;
		while (u_monitor.pkt_count == start_count && waited < max_clks) begin
			@(negedge usb_clk);
			waited++;
		end
		if (u_monitor.pkt_count == start_count) begin
			$display("[ERROR] t=%0t line monitor saw no complete packet in time", $time);
			error_count++;
		end
	endtask

	task automatic send_packet(input int idx);
		int start_pkts;
		int start_ready;
		int waited;
		start_pkts  = u_monitor.pkt_count;
		start_ready = ready_pulses;
		for (int b = 0; b < row_len[idx]; b++) begin
			tx_data  = row_bytes[idx][8*b +: 8];
			tx_valid = 1'b1;
			waited   = 0;
			do begin
				@(negedge usb_clk);
				waited++;
			end while (!tx_ready && waited < 12 * CLKS_PER_BIT);
			if (!tx_ready) begin
				$display("[ERROR] t=%0t byte %0d was never accepted", $time, b);
				error_count++;
			end
		end
		tx_valid = 1'b0;
		wait_monitor(start_pkts, (row_len[idx] * 9 + 8) * CLKS_PER_BIT);
		check_value("tx_ready pulses", ready_pulses - start_ready, row_len[idx]);
		check_value("rx byte count", u_monitor.rx_count, row_len[idx]);
		for (int b = 0; b < row_len[idx] && b < u_monitor.rx_count; b++)
			check_value($sformatf("rx_byte[%0d]", b), int'(u_monitor.rx_bytes[b]),
				int'(row_bytes[idx][8*b +: 8]));
		check_value("stuffed zeros", u_monitor.stuffed_count, row_stuff[idx]);
		check_value("eop se0 bit times", u_monitor.se0_bits, 2);
		check_value("eop j bit times", u_monitor.j_bits, 1);
		check_value("line errors", u_monitor.line_errs, 0);
	endtask

	task automatic send_bus_reset();
		int start_pkts;
		int waited;
		start_pkts     = u_monitor.pkt_count;
		generate_reset = 1'b1;
		waited         = 0;
		while (!txoe && waited < 3 * CLKS_PER_BIT) begin
			@(negedge usb_clk);
			waited++;
		end
		repeat (4 * CLKS_PER_BIT) @(negedge usb_clk); // the reset holds SE0 for a while
		check_value("txoe", int'(txoe), 1);
		check_value("txp", int'(txp), 0);
		check_value("txm", int'(txm), 0);
		generate_reset = 1'b0;
		waited         = 0;
		while (txoe && waited < 3 * CLKS_PER_BIT) begin
			@(negedge usb_clk);
			waited++;
		end
		check_value("txoe", int'(txoe), 0);
		check_value("txp", int'(txp), 1);
		check_value("txm", int'(txm), 0);
		wait_monitor(start_pkts, 4 * CLKS_PER_BIT);
		check_value("rx byte count", u_monitor.rx_count, 0);
	endtask

	task automatic report_test(input string label, input int errs_before);
		tests_run++;
		if (error_count == errs_before) begin
			$display("test %0d (%s) passed", tests_run, label);
		end else begin
			tests_failed++;
			$display("test %0d (%s) failed", tests_run, label);
		end
	endtask

	initial begin : main
		int errs_before;
		usb_clk        = 1'b0;
		usb_rst        = 1'b1;
		tx_data        = '0;
		tx_valid       = 1'b0;
		generate_reset = 1'b0;
		void'($urandom(71));
		set_row(0, 1, 1'b0, 0, 64'h00000000_000000A5);
		set_row(1, 0, 1'b1, 0, 64'h0);
		set_row(2, 4, 1'b0, 0, 64'h00000000_C3013C80);
		set_row(3, 1, 1'b0, 1, 64'h00000000_000000FF);
		set_row(4, 2, 1'b0, 2, 64'h00000000_0000FFFF);
		set_row(5, 2, 1'b0, 2, 64'h00000000_00007FFE); // ones run from 0xFE into 0x7F
		set_row(6, 2, 1'b0, 1, 64'h00000000_0000FC80); // stuffed zero right before EOP
		set_row(7, 1, 1'b0, 0, 64'h0);
		for (int r = NUM_FIXED; r < NUM_ROWS; r++) begin
			set_row(r, 1 + int'($urandom % 8), 1'b0, 0, {$urandom, $urandom});
			row_stuff[r] = count_six_runs(row_len[r], row_bytes[r]);
		end
		table_ready = 1'b1;
		repeat (5) @(negedge usb_clk);
		usb_rst = 1'b0;
		repeat (2) @(negedge usb_clk);
		errs_before = error_count;
		check_value("txoe", int'(txoe), 0);
		check_value("tx_ready", int'(tx_ready), 0);
		check_value("txp", int'(txp), 1);
		check_value("txm", int'(txm), 0);
		report_test("idle after reset", errs_before);
		for (int r = 0; r < NUM_ROWS; r++) begin
			errs_before = error_count;
			if (row_reset[r])
				send_bus_reset();
			else
				send_packet(r);
			report_test($sformatf("row %0d, %0d bytes", r, row_len[r]), errs_before);
		end
		$display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
			tests_run, tests_run - tests_failed, tests_failed, error_count);
		if (tests_failed == 0 && error_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// budget of 9 bit times per byte and 6 per packet, plus half again
	initial begin : watchdog
		int bits;
		wait (table_ready);
		bits = 0;
		for (int r = 0; r < NUM_ROWS; r++)
			bits = bits + row_len[r] * 9 + 6;
		#((bits * CLKS_PER_BIT * CLK_PERIOD * 3) / 2 + 10 * CLK_PERIOD);
		$display("[ERROR] t=%0t watchdog expired before the tests finished", $time);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== testbench/usb_line_monitor.sv ====
// ------------------------------
// USB line receiver model
// NRZI-decodes and destuffs the
// TX pair, packs bytes LSB first
// and measures the end of packet
// ------------------------------

`timescale 1ns/1ps

module usb_line_monitor #(
	parameter int CLKS_PER_BIT = 4
) (
	input logic usb_clk,
	input logic txp,
	input logic txm,
	input logic txoe
);

	logic [7:0] rx_bytes [16];
	int         rx_count      = 0;
	int         pkt_count     = 0; // completed packets, bumped after txoe falls
	int         stuffed_count = 0;
	int         se0_bits      = 0;
	int         j_bits        = 0;
	int         line_errs     = 0;

	initial begin : decode
		logic       prev_level;
		logic       bit_val;
		logic [7:0] shreg;
		int         ones;
		int         nbits;
		forever begin
			@(posedge txoe);
			prev_level    = 1'b1; // the pair idles in J before the first bit
			shreg         = '0;
			ones          = 0;
			nbits         = 0;
			rx_count      = 0;
			stuffed_count = 0;
			se0_bits      = 0;
			j_bits        = 0;
			line_errs     = 0;
			repeat (CLKS_PER_BIT / 2) @(negedge usb_clk); // move to mid bit
			while (txoe) begin
				if (txp && txm) begin
					line_errs++;
				end else if (!txp && !txm) begin
					se0_bits++;
				end else if (se0_bits > 0) begin
					if (txp)
						j_bits++;
					else
						line_errs++; // only J may follow the SE0
				end else begin
					bit_val    = (txp == prev_level); // no transition means a one
					prev_level = txp;
					if (ones == 6) begin
						if (bit_val)
							line_errs++; // a stuffed bit has to be a zero
						stuffed_count++;
						ones = 0;
					end else begin
						ones  = bit_val ? ones + 1 : 0;
						shreg = {bit_val, shreg[7:1]};
						nbits++;
						if (nbits == 8) begin
							if (rx_count < 16)
								rx_bytes[rx_count] = shreg;
							rx_count++;
							nbits = 0;
						end
					end
				end
				repeat (CLKS_PER_BIT) @(negedge usb_clk);
			end
			if (nbits != 0)
				line_errs++; // packet ended inside a byte
			pkt_count++;
		end
	end

endmodule
